// ==== rtl/i2c_timing_pkg.sv ====
package i2c_timing_pkg;

    // Wide enough for the longest count, the SCL low time
    localparam int timer_width = 6;

    // Bus phase that the timer is currently measuring
    typedef enum logic [2:0] {
        ph_idle,
        ph_bus_free,
        ph_start_hold,
        ph_scl_low,
        ph_scl_high,
        ph_stop_setup
    } bus_phase_t;

    // Counts at 25.2 MHz. Each phase lasts count+1 clocks
    localparam logic [timer_width-1:0] default_t_low      = timer_width'(37); // About 1.5 us
    localparam logic [timer_width-1:0] default_t_high     = timer_width'(24); // About 1.0 us
    localparam logic [timer_width-1:0] default_start_hold = timer_width'(16);
    localparam logic [timer_width-1:0] default_stop_setup = timer_width'(16);
    localparam logic [timer_width-1:0] default_bus_free   = timer_width'(35); // STOP to START

    // SDA hold after the falling SCL edge
    localparam logic [timer_width-1:0] default_sda_change = timer_width'(7);

endpackage

// ==== rtl/ch7301_cfg_pkg.sv ====
package ch7301_cfg_pkg;

    // 7-bit address 0x76 shifted up, write bit clear
    localparam logic [7:0] dev_addr_byte = 8'hEC;

    localparam int num_regs = 6;

    typedef logic [2:0] reg_index_t;

    // One register write on the bus
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] data;
    } reg_write_t;

    // The encoder expects bit 7 of the register address to be set
    localparam reg_write_t cfg_table [num_regs] = '{
        '{reg_addr: 8'hC9, data: 8'h00}, // Power management
        '{reg_addr: 8'hC8, data: 8'h18}, // Low two bits 01 give the color bar pattern
        '{reg_addr: 8'hB3, data: 8'hE4},
        '{reg_addr: 8'hA1, data: 8'h09},
        '{reg_addr: 8'h9F, data: 8'h83},
        '{reg_addr: 8'h9C, data: 8'h00}  // Written last
    };

endpackage

// ==== rtl/i2c_pad_io.sv ====
module i2c_pad_io #(
    parameter int filter_len = 1
) (
    input  logic clk25_2,
    input  logic rst_n,
    input  logic scl_release,
    input  logic sda_release,
    output logic sda_filt,
    output wire  scl,
    inout  wire  sda
);

    logic [filter_len-1:0] sda_sync; // Newest sample in bit 0
    logic                  filt_q;

    // Open drain: the pull-up provides the high level
    assign scl = scl_release ? 1'bz : 1'b0;
    assign sda = sda_release ? 1'bz : 1'b0;

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            sda_sync <= '1; // Idle bus reads high
            filt_q   <= 1'b1;
        end else begin
            sda_sync[0] <= sda;
            for (int i = 1; i < filter_len; i++) begin
                sda_sync[i] <= sda_sync[i-1];
            end
            filt_q <= sda_filt;
        end
    end

    // A new level passes only once every sample in the window agrees
    // Anything shorter than the window is treated as a spike
    always_comb begin
        if (&sda_sync) begin
            sda_filt = 1'b1;
        end else if (~|sda_sync) begin
            sda_filt = 1'b0;
        end else begin
            sda_filt = filt_q; // Mixed samples keep the old level
        end
    end

endmodule

// ==== rtl/i2c_phase_timer.sv ====
module i2c_phase_timer
    import i2c_timing_pkg::*;
#(
    parameter logic [timer_width-1:0] t_low          = default_t_low,
    parameter logic [timer_width-1:0] t_high         = default_t_high,
    parameter logic [timer_width-1:0] start_hold     = default_start_hold,
    parameter logic [timer_width-1:0] stop_setup     = default_stop_setup,
    parameter logic [timer_width-1:0] bus_free       = default_bus_free,
    parameter logic [timer_width-1:0] sda_change_cnt = default_sda_change
) (
    input  logic       clk25_2,
    input  logic       rst_n,
    input  bus_phase_t phase,
    output logic       phase_done,
    output logic       sda_change
);

    bus_phase_t             phase_q;
    logic [timer_width-1:0] count_q;
    logic [timer_width-1:0] count;  // Cycles spent in the current phase
    logic [timer_width-1:0] target;

    // The first cycle of a new phase reads as zero
    assign count = (phase != phase_q) ? '0 : count_q;

    always_comb begin
        case (phase)
            ph_bus_free:   target = bus_free;
            ph_start_hold: target = start_hold;
            ph_scl_low:    target = t_low;
            ph_scl_high:   target = t_high;
            ph_stop_setup: target = stop_setup;
            default:       target = '0;
        endcase
    end

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= ph_idle;
            count_q <= '0;
        end else begin
            phase_q <= phase;
            if (phase == ph_idle) begin
                count_q <= '0; // Nothing to time while idle
            end else begin
                count_q <= count + 1'b1;
            end
        end
    end

    assign phase_done = (phase != ph_idle) && (count == target);
    assign sda_change = (phase == ph_scl_low) && (count == sda_change_cnt);

endmodule

// ==== rtl/i2c_write_engine.sv ====
module i2c_write_engine
    import i2c_timing_pkg::*;
    import ch7301_cfg_pkg::*;
(
    input  logic       clk25_2,
    input  logic       rst_n,
    input  logic       xfer_start,
    input  logic       xfer_last,
    input  logic       phase_done,
    input  logic       sda_change,
    input  logic       sda_filt,
    input  reg_write_t xfer_word,
    output bus_phase_t phase,
    output logic       scl_release,
    output logic       sda_release,
    output logic       xfer_done
);

    typedef enum logic [3:0] {
        st_idle,
        st_bus_free,
        st_start_hold,
        st_bit_low,
        st_bit_high,
        st_ack_check,
        st_stop_high,
        st_stop_low,
        st_stop_setup
    } eng_state_t;

    eng_state_t state;
    logic       start_pend; // Start seen while the bus free wait runs
    logic [1:0] byte_cnt;   // 0 device address, 1 register, 2 data
    logic [3:0] bit_cnt;    // 8 means the ACK bit
    logic [7:0] shift_q;
    logic       start_req;
    logic       begin_start;
    logic       ack_bit;
    logic       next_byte;
    logic       send_bit;

    assign start_req   = xfer_start | start_pend;
    assign begin_start = (state == st_bus_free) && phase_done && start_req;
    assign ack_bit     = (bit_cnt == 4'd8);
    assign next_byte   = (state == st_ack_check) && !sda_filt && (byte_cnt != 2'd2);
    assign send_bit    = (state == st_bit_low) && sda_change && !ack_bit;

    // The ACK check cycle stays in the high phase so SCL high time is unbroken
    always_comb begin
        case (state)
            st_bus_free:                            phase = ph_bus_free;
            st_start_hold:                          phase = ph_start_hold;
            st_bit_low, st_stop_low:                phase = ph_scl_low;
            st_bit_high, st_ack_check, st_stop_high: phase = ph_scl_high;
            st_stop_setup:                          phase = ph_stop_setup;
            default:                                phase = ph_idle;
        endcase
    end

    // Bytes go out MSB first
    always_ff @(posedge clk25_2) begin
        if (begin_start) begin
            shift_q <= dev_addr_byte;
        end else if (next_byte) begin
            shift_q <= (byte_cnt == 2'd0) ? xfer_word.reg_addr : xfer_word.data;
        end else if (send_bit) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            start_pend  <= 1'b0;
            byte_cnt    <= 2'd0;
            bit_cnt     <= 4'd0;
            scl_release <= 1'b1;
            sda_release <= 1'b1;
            xfer_done   <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            if (xfer_start) begin
                start_pend <= 1'b1;
            end

            case (state)
                st_idle: begin
                    if (start_req) begin
                        state <= st_bus_free;
                    end
                end

                st_bus_free: begin
                    if (phase_done) begin
                        if (start_req) begin
                            sda_release <= 1'b0; // START with SCL still high
                            start_pend  <= 1'b0;
                            byte_cnt    <= 2'd0;
                            bit_cnt     <= 4'd0;
                            state       <= st_start_hold;
                        end else begin
                            state <= st_idle;
                        end
                    end
                end

                st_start_hold: begin
                    if (phase_done) begin
                        scl_release <= 1'b0;
                        state       <= st_bit_low;
                    end
                end

                st_bit_low: begin
                    if (sda_change) begin
                        sda_release <= ack_bit ? 1'b1 : shift_q[7]; // Let go for the slave's ACK
                    end
                    if (phase_done) begin
                        scl_release <= 1'b1;
                        if (ack_bit) begin
                            state <= st_ack_check;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                            state   <= st_bit_high;
                        end
                    end
                end

                st_bit_high: begin
                    if (phase_done) begin
                        scl_release <= 1'b0;
                        state       <= st_bit_low;
                    end
                end

                // A NACK or the end of the data byte both lead to STOP
                st_ack_check: begin
                    if (next_byte) begin
                        bit_cnt  <= 4'd0;
                        byte_cnt <= byte_cnt + 2'd1;
                        state    <= st_bit_high;
                    end else begin
                        state <= st_stop_high;
                    end
                end

                st_stop_high: begin
                    if (phase_done) begin
                        scl_release <= 1'b0;
                        state       <= st_stop_low;
                    end
                end

                st_stop_low: begin
                    if (sda_change) begin
                        sda_release <= 1'b0; // SDA must be low before SCL rises
                    end
                    if (phase_done) begin
                        scl_release <= 1'b1;
                        state       <= st_stop_setup;
                    end
                end

                st_stop_setup: begin
                    if (phase_done) begin
                        sda_release <= 1'b1; // STOP
                        xfer_done   <= 1'b1;
                        state       <= xfer_last ? st_idle : st_bus_free;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// ==== rtl/init_sequencer.sv ====
module init_sequencer
    import ch7301_cfg_pkg::*;
(
    input  logic       clk25_2,
    input  logic       rst_n,
    input  logic       enable,
    input  logic       xfer_done,
    output logic       xfer_start,
    output logic       xfer_last,
    output logic       complete,
    output reg_write_t xfer_word
);

    typedef enum logic [1:0] {
        sq_idle,
        sq_issue,
        sq_wait
    } seq_state_t;

    seq_state_t state;
    reg_index_t index;

    // Index only moves on xfer_done, so the word is stable for the whole write
    assign xfer_word = cfg_table[index];
    assign xfer_last = (index == reg_index_t'(num_regs - 1));

    always_ff @(posedge clk25_2 or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sq_idle;
            index      <= '0;
            xfer_start <= 1'b0;
            complete   <= 1'b0;
        end else begin
            xfer_start <= 1'b0;
            case (state)
                sq_idle: begin
                    if (enable) begin
                        index <= '0;
                        state <= sq_issue;
                    end
                end
                sq_issue: begin
                    xfer_start <= 1'b1;
                    state      <= sq_wait;
                end
                sq_wait: begin
                    if (xfer_done) begin
                        if (xfer_last) begin
                            complete <= 1'b1; // Held until reset
                            state    <= sq_idle;
                        end else begin
                            index <= index + 1'b1;
                            state <= sq_issue;
                        end
                    end
                end
                default: begin
                    state <= sq_idle;
                end
            endcase
        end
    end

endmodule

// ==== rtl/chrontel_init_top.sv ====
module chrontel_init_top
    import i2c_timing_pkg::*;
    import ch7301_cfg_pkg::*;
#(
    parameter logic [timer_width-1:0] t_low          = default_t_low,
    parameter logic [timer_width-1:0] t_high         = default_t_high,
    parameter logic [timer_width-1:0] start_hold     = default_start_hold,
    parameter logic [timer_width-1:0] stop_setup     = default_stop_setup,
    parameter logic [timer_width-1:0] bus_free       = default_bus_free,
    parameter logic [timer_width-1:0] sda_change_cnt = default_sda_change,
    parameter int                     filter_len     = 1
) (
    input  logic clk25_2,
    input  logic rst_n,
    input  logic enable,
    output logic complete,
    output wire  scl,
    inout  wire  sda
);

    logic       xfer_start;
    logic       xfer_last;
    logic       xfer_done;
    reg_write_t xfer_word;
    bus_phase_t phase;
    logic       phase_done;
    logic       sda_change;
    logic       scl_release;
    logic       sda_release;
    logic       sda_filt;

    init_sequencer seq_i (
        .clk25_2   (clk25_2),
        .rst_n     (rst_n),
        .enable    (enable),
        .xfer_done (xfer_done),
        .xfer_start(xfer_start),
        .xfer_last (xfer_last),
        .complete  (complete),
        .xfer_word (xfer_word)
    );

    i2c_write_engine engine_i (
        .clk25_2    (clk25_2),
        .rst_n      (rst_n),
        .xfer_start (xfer_start),
        .xfer_last  (xfer_last),
        .phase_done (phase_done),
        .sda_change (sda_change),
        .sda_filt   (sda_filt),
        .xfer_word  (xfer_word),
        .phase      (phase),
        .scl_release(scl_release),
        .sda_release(sda_release),
        .xfer_done  (xfer_done)
    );

    i2c_phase_timer #(
        .t_low         (t_low),
        .t_high        (t_high),
        .start_hold    (start_hold),
        .stop_setup    (stop_setup),
        .bus_free      (bus_free),
        .sda_change_cnt(sda_change_cnt)
    ) timer_i (
        .clk25_2   (clk25_2),
        .rst_n     (rst_n),
        .phase     (phase),
        .phase_done(phase_done),
        .sda_change(sda_change)
    );

    i2c_pad_io #(
        .filter_len(filter_len)
    ) pads_i (
        .clk25_2    (clk25_2),
        .rst_n      (rst_n),
        .scl_release(scl_release),
        .sda_release(sda_release),
        .sda_filt   (sda_filt),
        .scl        (scl),
        .sda        (sda)
    );

endmodule

// ==== tb/i2c_slave_model.sv ====
module i2c_slave_model (
    input  logic clk25_2,
    input  logic rst_n,
    input  wire  scl,
    inout  wire  sda,
    input  int   nack_txn,
    input  int   nack_byte,
    output logic timing_error
);

    localparam int max_txns     = 16;
    localparam int max_bytes    = 4;
    localparam int min_low      = 38; // t_low+1 clocks
    localparam int min_high     = 25; // t_high+1 clocks
    localparam int min_bus_free = 36; // bus_free+1 clocks

    logic [7:0] rx_bytes [max_txns][max_bytes];
    int         rx_len   [max_txns];
    logic [3:0] rx_ack   [max_txns]; // Bit n holds the level seen on the ACK clock of byte n
    logic       rx_stop  [max_txns];
    int         start_count;
    int         stop_count;

    logic       pull_sda;
    logic       scl_q;
    logic       sda_q;
    logic       in_txn;
    logic       stop_seen;
    logic [7:0] shift;
    int         cur;
    int         bit_cnt;   // Rising SCL edges in this byte, 9 once the ACK is clocked
    int         byte_cnt;
    int         level_cnt; // Samples since the last SCL edge
    int         free_cnt;

    assign sda = pull_sda ? 1'b0 : 1'bz;

    initial begin
        pull_sda     = 1'b0;
        timing_error = 1'b0;
    end

    task automatic flag_violation(string what);
        $display("I2C slave: %s at time %0t", what, $time);
        timing_error = 1'b1;
    endtask

    task automatic print_transaction(int idx);
        string bytes_txt;
        bytes_txt = "";
        for (int b = 0; b < rx_len[idx] && b < max_bytes; b++) begin
            bytes_txt = {bytes_txt, $sformatf(" %h", rx_bytes[idx][b])};
        end
        $display("I2C slave: transaction %0d, bytes%s, ACK pattern %b, STOP seen",
                 idx, bytes_txt, rx_ack[idx][2:0]);
    endtask

    task automatic open_transaction();
        if (in_txn) begin
            flag_violation("SDA fell while SCL was high inside a transaction");
        end else if (stop_seen && free_cnt < min_bus_free) begin
            flag_violation($sformatf("bus free time was only %0d cycles", free_cnt));
        end
        if (start_count >= max_txns) begin
            flag_violation("more transactions arrived than the model can record");
        end else begin
            cur               = start_count;
            start_count       = start_count + 1;
            rx_len[cur]       = 0;
            rx_ack[cur]       = 4'b0000;
            rx_stop[cur]      = 1'b0;
            in_txn            = 1'b1;
            bit_cnt           = 0;
            byte_cnt          = 0;
        end
    endtask

    // A legal STOP follows the first clock after a byte boundary
    task automatic close_transaction();
        if (!in_txn || bit_cnt != 1) begin
            flag_violation("SDA rose while SCL was high in the middle of a byte");
        end else begin
            rx_stop[cur] = 1'b1;
            stop_count   = stop_count + 1;
            print_transaction(cur);
        end
        in_txn    = 1'b0;
        stop_seen = 1'b1;
        free_cnt  = 0;
    endtask

    task automatic scl_rise();
        if (level_cnt < min_low) begin
            flag_violation($sformatf("SCL low lasted only %0d cycles", level_cnt));
        end
        if (in_txn) begin
            if (bit_cnt < 8) begin
                shift   = {shift[6:0], sda}; // MSB first
                bit_cnt = bit_cnt + 1;
            end else if (bit_cnt == 8) begin
                if (byte_cnt <= max_bytes) begin
                    rx_ack[cur][byte_cnt-1] = sda;
                end
                bit_cnt = 9;
            end
        end
    endtask

    task automatic scl_fall();
        if (level_cnt < min_high) begin
            flag_violation($sformatf("SCL high lasted only %0d cycles", level_cnt));
        end
        if (in_txn) begin
            if (bit_cnt == 8) begin
                if (byte_cnt < max_bytes) begin
                    rx_bytes[cur][byte_cnt] = shift;
                end else begin
                    flag_violation("a transaction ran longer than four bytes");
                end
                // Pull SDA low for an ACK unless this byte is the one to refuse
                pull_sda <= !((cur == nack_txn) && (byte_cnt == nack_byte));
                byte_cnt    = byte_cnt + 1;
                rx_len[cur] = byte_cnt;
            end else if (bit_cnt == 9) begin
                pull_sda <= 1'b0; // Hand SDA back to the master
                bit_cnt = 0;
            end
        end
    endtask

    // Sampled on the falling clock edge, where the DUT outputs are settled
    always @(negedge clk25_2) begin
        if (!rst_n) begin
            pull_sda <= 1'b0;
            scl_q       = 1'b1;
            sda_q       = 1'b1;
            in_txn      = 1'b0;
            stop_seen   = 1'b0;
            bit_cnt     = 0;
            byte_cnt    = 0;
            level_cnt   = 0;
            free_cnt    = 0;
            start_count = 0;
            stop_count  = 0;
        end else begin
            if (stop_seen) begin
                free_cnt = free_cnt + 1;
            end
            if (scl_q && scl && (sda !== sda_q)) begin
                if (sda === 1'b0) begin
                    open_transaction();
                end else begin
                    close_transaction();
                end
            end
            if (scl !== scl_q) begin
                if (scl === 1'b1) begin
                    scl_rise();
                end else begin
                    scl_fall();
                end
                level_cnt = 1;
            end else begin
                level_cnt = level_cnt + 1;
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

// ==== tb/tb_chrontel_init.sv ====
module tb_chrontel_init
    import ch7301_cfg_pkg::*;
();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int idle_cycles  = 2000;
    localparam int bit_cycles   = 38 + 25; // SCL low t_low+1, high t_high+1
    // Bus free, START hold, 27 bits, the STOP clock and STOP setup
    localparam int txn_cycles   = 36 + 17 + 27 * bit_cycles + bit_cycles + 17;
    localparam int seq_cycles   = num_regs * txn_cycles;
    localparam int max_cycles   = 120000; // Well above two sequences and two idle windows

    logic   clk25_2;
    logic   rst_n;
    logic   enable;
    logic   complete;
    wire    scl;
    wire    sda;
    int     nack_txn;
    int     nack_byte;
    logic   timing_error;
    int     cycle_count;
    integer seed;

    pullup (scl);
    pullup (sda);

    chrontel_init_top dut_i (
        .clk25_2 (clk25_2),
        .rst_n   (rst_n),
        .enable  (enable),
        .complete(complete),
        .scl     (scl),
        .sda     (sda)
    );

    i2c_slave_model slave_i (
        .clk25_2     (clk25_2),
        .rst_n       (rst_n),
        .scl         (scl),
        .sda         (sda),
        .nack_txn    (nack_txn),
        .nack_byte   (nack_byte),
        .timing_error(timing_error)
    );

    initial begin
        clk25_2 = 1'b0;
        forever #(clk_period / 2) clk25_2 = ~clk25_2;
    end

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_bit(string test, logic exp, logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected %b, actual %b", test, exp, act));
        end
    endtask

    task automatic check_byte(string test, logic [7:0] exp, logic [7:0] act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_word(string test, reg_write_t exp, reg_write_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected %h/%h, actual %h/%h", test,
                                     exp.reg_addr, exp.data, act.reg_addr, act.data));
        end
    endtask

    task automatic check_count(string test, int exp, int act);
        if (act != exp) begin
            report_failure($sformatf("ERROR %s: expected %0d, actual %0d", test, exp, act));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk25_2);
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk25_2);
        rst_n = 1'b1;
    endtask

    task automatic wait_for_complete(string test);
        int waited;
        waited = 0;
        while (complete !== 1'b1) begin
            if (waited >= seq_cycles + 100) begin
                report_failure($sformatf("%s: complete did not rise within %0d cycles",
                                         test, waited));
            end else begin
                @(negedge clk25_2);
                waited = waited + 1;
            end
        end
        check_count({test, " STOPs before complete"}, num_regs, slave_i.stop_count);
    endtask

    // Expected bytes come from the device address and the table, in send order
    task automatic check_sequence(string test, int bad_txn, int bad_byte);
        int         exp_len;
        logic [7:0] exp_bytes [3];
        reg_write_t got;
        string      name;
        check_count({test, " transactions"}, num_regs, slave_i.start_count);
        for (int t = 0; t < num_regs; t++) begin
            name         = $sformatf("%s txn %0d", test, t);
            exp_bytes[0] = dev_addr_byte;
            exp_bytes[1] = cfg_table[t].reg_addr;
            exp_bytes[2] = cfg_table[t].data;
            exp_len      = (t == bad_txn) ? bad_byte + 1 : 3;
            check_count({name, " length"}, exp_len, slave_i.rx_len[t]);
            for (int b = 0; b < exp_len; b++) begin
                // A complete write has its register and data bytes compared as one word
                if (b == 0 || exp_len < 3) begin
                    check_byte($sformatf("%s byte %0d", name, b), exp_bytes[b],
                               slave_i.rx_bytes[t][b]);
                end
                check_bit($sformatf("%s ack %0d", name, b), (t == bad_txn) && (b == bad_byte),
                          slave_i.rx_ack[t][b]);
            end
            if (exp_len == 3) begin
                got = {slave_i.rx_bytes[t][1], slave_i.rx_bytes[t][2]};
                check_word({name, " word"}, cfg_table[t], got);
            end
            check_bit({name, " stop"}, 1'b1, slave_i.rx_stop[t]);
        end
    endtask

    task automatic test_reset_state();
        enable = 1'b0;
        repeat (idle_cycles) begin
            @(negedge clk25_2);
            check_bit("reset_state scl", 1'b1, scl);
            check_bit("reset_state sda", 1'b1, sda);
            check_bit("reset_state complete", 1'b0, complete);
        end
        check_count("reset_state starts", 0, slave_i.start_count);
    endtask

    // The slave checks bus timing on every edge while this runs
    task automatic test_full_sequence();
        enable = 1'b1;
        wait_for_complete("full_sequence");
        check_sequence("full_sequence", -1, -1);
    endtask

    task automatic test_complete_holds();
        enable = 1'b0; // Left high, the idle sequencer would start over
        repeat (idle_cycles) begin
            @(negedge clk25_2);
            check_bit("complete_holds complete", 1'b1, complete);
            check_bit("complete_holds scl", 1'b1, scl);
            check_bit("complete_holds sda", 1'b1, sda);
        end
        check_count("complete_holds starts", num_regs, slave_i.start_count);
    endtask

    task automatic test_nack_recovery();
        nack_txn  = $unsigned($random(seed)) % num_regs;
        nack_byte = $unsigned($random(seed)) % 3;
        $display("NACK on byte %0d of transaction %0d", nack_byte, nack_txn);
        apply_reset(); // complete only clears on reset
        enable = 1'b1;
        wait_for_complete("nack_recovery");
        enable = 1'b0;
        check_sequence("nack_recovery", nack_txn, nack_byte);
    endtask

    always @(posedge clk25_2) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            report_failure($sformatf("Timeout: the run went past %0d cycles", max_cycles));
        end
    end

    initial begin
        wait (timing_error === 1'b1);
        report_failure("The I2C slave model saw a bus timing violation");
    end

    initial begin
        seed        = 32'h18fa;
        rst_n       = 1'b0;
        enable      = 1'b0;
        nack_txn    = -1;
        nack_byte   = -1;
        cycle_count = 0;
        apply_reset();
        test_reset_state();
        test_full_sequence();
        test_complete_holds();
        test_nack_recovery();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== chrontel_init.f ====
rtl/i2c_timing_pkg.sv
rtl/ch7301_cfg_pkg.sv
rtl/i2c_pad_io.sv
rtl/i2c_phase_timer.sv
rtl/i2c_write_engine.sv
rtl/init_sequencer.sv
rtl/chrontel_init_top.sv
tb/i2c_slave_model.sv
tb/tb_chrontel_init.sv

// ==== Bender.yml ====
package:
  name: chrontel_init

sources:
  - rtl/i2c_timing_pkg.sv
  - rtl/ch7301_cfg_pkg.sv
  - rtl/i2c_pad_io.sv
  - rtl/i2c_phase_timer.sv
  - rtl/i2c_write_engine.sv
  - rtl/init_sequencer.sv
  - rtl/chrontel_init_top.sv
  - target: test
    files:
      - tb/i2c_slave_model.sv
      - tb/tb_chrontel_init.sv
